// ==== logic/dupPkg.sv ====
// Shared types and constants for the synchronous serial line unit.
// Modules refer to these by scoped name, dupPkg::name.

`default_nettype none

package dupPkg;

   ////////////////////////////////////////////////////////////
   // Enumerations
   ////////////////////////////////////////////////////////////

   // Maintenance mode select
   typedef enum logic [1:0]
   {
      MODE_USER = 2'd0,   // External clocks and data
      MODE_EXT  = 2'd1,   // External loopback, timer running
      MODE_INT  = 2'd2,   // Internal loopback
      MODE_DIAG = 2'd3    // Host bit-bangs the clock
   } maintMode_t;

   // Control FSM states
   typedef enum logic [1:0]
   {
      ST_OFF      = 2'd0,
      ST_PREAMBLE = 2'd1,
      ST_DATA     = 2'd2
   } ctlState_t;

   ////////////////////////////////////////////////////////////
   // Character type and sync constants
   ////////////////////////////////////////////////////////////

   // One serial character
   typedef logic [7:0] dupByte_t;

   // Sync pattern, also sent as fill when idle
   localparam dupByte_t SYN_CHAR = 8'h96;

   // Sync characters sent after enable
   localparam logic [3:0] PREAMBLE_COUNT = 4'd2;

endpackage

`default_nettype wire

// ==== logic/dupClockIf.sv ====
// Bit clock, maintenance timer and line clock enables.
// Driven by the clock block, read by control, transmitter and receiver.

`default_nettype none

interface dupClockIf;

   logic serialClk;    // Bit clock, divided or from mco
   logic maintTimer;   // Timer copy of the bit clock
   logic txClkEn;      // Rising edge of transmit line clock
   logic rxClkEn;      // Falling edge of receive line clock

   // Clock block side
   modport source (output serialClk, output maintTimer, output txClkEn, output rxClkEn);

   // User side
   modport sink (input serialClk, input maintTimer, input txClkEn, input rxClkEn);

endinterface

`default_nettype wire

// ==== logic/dupClock.sv ====
// Bit clock divider, maintenance timer and line clock edge detection.
// CLK_DIV sets the half-period count; the line clocks come from the control block.

`default_nettype none

module dupClock #(
   parameter logic [10:0] CLK_DIV = 11'd4
) (
   input  wire                 clk,
   input  wire                 rst,
   input  dupPkg::maintMode_t  mode,
   input  wire                 mco,
   input  wire                 txLineClk,
   input  wire                 rxLineClk,
   dupClockIf.source           clocks
);

   logic [10:0] count;
   logic        halfStage;
   logic        bitClk;
   logic        txSample;
   logic        txPrev;
   logic        rxSample;
   logic        rxPrev;
   logic        diagMode;

   // Divider stops while the host drives the clock
   assign diagMode = (mode == dupPkg::MODE_DIAG);

   ////////////////////////////////////////////////////////////
   // Divider chain
   ////////////////////////////////////////////////////////////

   // Tick every CLK_DIV+1 cycles, then two toggle stages
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count     <= CLK_DIV;
         halfStage <= 1'b0;
         bitClk    <= 1'b0;
      end
      else if (diagMode)
      begin
         count     <= CLK_DIV;
         halfStage <= 1'b0;
         bitClk    <= 1'b0;
      end
      else if (count == 11'd0)
      begin
         count     <= CLK_DIV;
         halfStage <= ~halfStage;
         // Second stage toggles on every other tick
         if (halfStage)
            bitClk <= ~bitClk;
      end
      else
         count <= count - 11'd1;
   end

   // mco passes straight through in diagnostic mode
   assign clocks.serialClk = diagMode ? mco : bitClk;

   // Timer only runs in the two loopback modes
   assign clocks.maintTimer = bitClk &
                              ((mode == dupPkg::MODE_EXT) || (mode == dupPkg::MODE_INT));

   ////////////////////////////////////////////////////////////
   // Line clock edge detectors
   ////////////////////////////////////////////////////////////

   // Sample, keep the previous sample, register the edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         txSample       <= 1'b0;
         txPrev         <= 1'b0;
         rxSample       <= 1'b0;
         rxPrev         <= 1'b0;
         clocks.txClkEn <= 1'b0;
         clocks.rxClkEn <= 1'b0;
      end
      else
      begin
         txSample       <= txLineClk;
         txPrev         <= txSample;
         rxSample       <= rxLineClk;
         rxPrev         <= rxSample;
         // Transmit on rising edge, receive on falling edge
         clocks.txClkEn <= txSample & ~txPrev;
         clocks.rxClkEn <= ~rxSample & rxPrev;
      end
   end

   // Enables are single-cycle pulses
   txEnPulse: assert property (@(posedge clk) disable iff (rst)
      clocks.txClkEn |=> !clocks.txClkEn);

endmodule

`default_nettype wire

// ==== logic/dupTransmitter.sv ====
// Transmit shift register, LSB first, one bit per transmit clock enable.
// Requests the next character from the control block at each byte boundary.

`default_nettype none

module dupTransmitter (
   input  wire              clk,
   input  wire              rst,
   dupClockIf.sink          clocks,
   input  dupPkg::dupByte_t nextByte,
   input  wire              sendEnable,
   output logic             byteReq,
   output logic             txSerial
);

   dupPkg::dupByte_t shiftReg;
   logic [2:0]       bitCount;

   // Boundary when the counter has run out
   assign byteReq = clocks.txClkEn & (bitCount == 3'd0);

   ////////////////////////////////////////////////////////////
   // Shift register and bit counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         shiftReg <= dupPkg::SYN_CHAR;
         bitCount <= 3'd0;
         txSerial <= 1'b1;
      end
      else if (clocks.txClkEn)
      begin
         if (bitCount == 3'd0)
         begin
            if (sendEnable)
            begin
               // Bit 0 goes out now, seven remain
               txSerial <= nextByte[0];
               shiftReg <= {1'b1, nextByte[7:1]};
               bitCount <= 3'd7;
            end
            else
            begin
               // Idle at mark, counter held
               txSerial <= 1'b1;
            end
         end
         else
         begin
            txSerial <= shiftReg[0];
            shiftReg <= {1'b1, shiftReg[7:1]};
            bitCount <= bitCount - 3'd1;
         end
      end
   end

   // A character taken at a boundary is fully defined
   reqByteKnown: assert property (@(posedge clk) disable iff (rst)
      (byteReq && sendEnable) |-> !$isunknown(nextByte));

endmodule

`default_nettype wire

// ==== logic/dupReceiver.sv ====
// Receive shift register with sync hunt and byte assembly.
// Samples one bit per receive clock enable; hunt restarts the search.

`default_nettype none

module dupReceiver (
   input  wire              clk,
   input  wire              rst,
   dupClockIf.sink          clocks,
   input  wire              rxSerial,
   input  wire              hunt,
   output dupPkg::dupByte_t rxByte,
   output logic             byteValid,
   output logic             synced
);

   dupPkg::dupByte_t shiftReg;
   dupPkg::dupByte_t nextShift;
   logic [2:0]       bitCount;

   // LSB first, so new bits enter at the top
   assign nextShift = {rxSerial, shiftReg[7:1]};

   ////////////////////////////////////////////////////////////
   // Hunt and assembly
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         shiftReg  <= '0;
         bitCount  <= 3'd0;
         synced    <= 1'b0;
         byteValid <= 1'b0;
      end
      else
      begin
         byteValid <= 1'b0;
         if (hunt)
         begin
            // Back to sync search
            synced   <= 1'b0;
            bitCount <= 3'd0;
         end
         else if (clocks.rxClkEn)
         begin
            shiftReg <= nextShift;
            if (!synced)
            begin
               // Compare on every sample while hunting
               if (nextShift == dupPkg::SYN_CHAR)
               begin
                  synced   <= 1'b1;
                  bitCount <= 3'd0;
               end
            end
            else
            begin
               bitCount <= bitCount + 3'd1;
               // Eighth sample completes a character
               if (bitCount == 3'd7)
                  byteValid <= 1'b1;
            end
         end
      end
   end

   // Character register, loaded with the eighth sample
   always_ff @(posedge clk)
   begin
      if (clocks.rxClkEn && synced && !hunt && (bitCount == 3'd7))
         rxByte <= nextShift;
   end

endmodule

`default_nettype wire

// ==== logic/dupControl.sv ====
// Mode and loopback routing, transmit buffer, preamble FSM and fill filter.
// Sits between the top-level pins and the clock, transmit and receive blocks.

`default_nettype none

module dupControl (
   input  wire                 clk,
   input  wire                 rst,
   input  dupPkg::maintMode_t  mode,
   input  wire                 enable,
   input  dupPkg::dupByte_t    txData,
   input  wire                 txLoad,
   input  wire                 txClkIn,
   input  wire                 rxClkIn,
   input  wire                 rxd,
   input  wire                 byteReq,
   input  wire                 txSerial,
   input  dupPkg::dupByte_t    rxByte,
   input  wire                 byteValid,
   input  wire                 synced,
   dupClockIf.sink             clocks,
   output logic                txBusy,
   output dupPkg::dupByte_t    rxData,
   output logic                rxValid,
   output logic                rxSynced,
   output logic                txd,
   output logic                txLineClk,
   output logic                rxLineClk,
   output dupPkg::dupByte_t    nextByte,
   output logic                sendEnable,
   output logic                rxSerial,
   output logic                hunt
);

   dupPkg::ctlState_t  state;
   dupPkg::maintMode_t modeQ;
   dupPkg::dupByte_t   txBuf;
   logic [3:0]         preCount;
   logic               extLine;

   ////////////////////////////////////////////////////////////
   // Loopback routing
   ////////////////////////////////////////////////////////////

   // User and external loopback use the pins
   assign extLine = (mode == dupPkg::MODE_USER) || (mode == dupPkg::MODE_EXT);

   assign txLineClk = extLine ? txClkIn : clocks.serialClk;
   assign rxLineClk = extLine ? rxClkIn : clocks.serialClk;
   assign rxSerial  = extLine ? rxd : txSerial;

   // Line held at mark when looped inside or switched off
   assign txd = (extLine && (state != dupPkg::ST_OFF)) ? txSerial : 1'b1;

   ////////////////////////////////////////////////////////////
   // Preamble FSM and transmit buffer
   ////////////////////////////////////////////////////////////

   // Sync while in preamble, fill when the buffer is empty
   assign sendEnable = (state != dupPkg::ST_OFF);
   assign nextByte   = ((state == dupPkg::ST_DATA) && txBusy) ? txBuf : dupPkg::SYN_CHAR;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= dupPkg::ST_OFF;
         preCount <= 4'd0;
         txBusy   <= 1'b0;
      end
      else if (!enable)
      begin
         // Disable drops any pending byte
         state  <= dupPkg::ST_OFF;
         txBusy <= 1'b0;
      end
      else
      begin
         case (state)
            dupPkg::ST_OFF:
            begin
               state    <= dupPkg::ST_PREAMBLE;
               preCount <= 4'd0;
            end
            dupPkg::ST_PREAMBLE:
            begin
               // Count sync characters taken by the transmitter
               if (byteReq)
               begin
                  preCount <= preCount + 4'd1;
                  if (preCount == dupPkg::PREAMBLE_COUNT - 4'd1)
                     state <= dupPkg::ST_DATA;
               end
            end
            default:
               state <= dupPkg::ST_DATA;
         endcase

         // Load only when empty, free once the transmitter takes it
         if (txLoad && !txBusy && (state != dupPkg::ST_OFF))
            txBusy <= 1'b1;
         else if (byteReq && txBusy && (state == dupPkg::ST_DATA))
            txBusy <= 1'b0;
      end
   end

   // Buffer payload
   always_ff @(posedge clk)
   begin
      if (txLoad && !txBusy && enable && (state != dupPkg::ST_OFF))
         txBuf <= txData;
   end

   ////////////////////////////////////////////////////////////
   // Receive side
   ////////////////////////////////////////////////////////////

   // Hunt held while off, one cycle on a mode change
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         modeQ    <= dupPkg::MODE_USER;
         hunt     <= 1'b1;
         rxSynced <= 1'b0;
         rxValid  <= 1'b0;
      end
      else
      begin
         modeQ    <= mode;
         hunt     <= !enable || (mode != modeQ);
         rxSynced <= synced && enable;
         // Fill characters never reach the host
         rxValid  <= byteValid && (rxByte != dupPkg::SYN_CHAR);
      end
   end

   always_ff @(posedge clk)
   begin
      if (byteValid && (rxByte != dupPkg::SYN_CHAR))
         rxData <= rxByte;
   end

   // Buffer is always empty while switched off
   offIdle: assert property (@(posedge clk) disable iff (rst)
      (state == dupPkg::ST_OFF) |-> !txBusy);

endmodule

`default_nettype wire

// ==== logic/dupLink.sv ====
// Top level of the serial line unit, plain ports only.
// Ties clock, control, transmit and receive blocks together.

`default_nettype none

module dupLink #(
   parameter logic [10:0] CLK_DIV = 11'd4
) (
   input  wire                 clk,
   input  wire                 rst,
   input  dupPkg::maintMode_t  mode,
   input  wire                 mco,
   input  wire                 enable,
   input  dupPkg::dupByte_t    txData,
   input  wire                 txLoad,
   input  wire                 txClkIn,
   input  wire                 rxClkIn,
   input  wire                 rxd,
   output logic                txBusy,
   output dupPkg::dupByte_t    rxData,
   output logic                rxValid,
   output logic                rxSynced,
   output logic                txd,
   output logic                serialClk,
   output logic                maintTimer
);

   // Internal wiring between the blocks
   logic             txLineClk;
   logic             rxLineClk;
   logic             byteReq;
   logic             txSerial;
   logic             sendEnable;
   logic             rxSerial;
   logic             hunt;
   logic             byteValid;
   logic             synced;
   dupPkg::dupByte_t nextByte;
   dupPkg::dupByte_t rxByte;

   dupClockIf clocks ();

   // Clocks out to the pins
   assign serialClk  = clocks.serialClk;
   assign maintTimer = clocks.maintTimer;

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   dupClock #(
      .CLK_DIV (CLK_DIV)
   ) clock0 (
      .clk       (clk),
      .rst       (rst),
      .mode      (mode),
      .mco       (mco),
      .txLineClk (txLineClk),
      .rxLineClk (rxLineClk),
      .clocks    (clocks.source)
   );

   dupControl control0 (
      .clk        (clk),
      .rst        (rst),
      .mode       (mode),
      .enable     (enable),
      .txData     (txData),
      .txLoad     (txLoad),
      .txClkIn    (txClkIn),
      .rxClkIn    (rxClkIn),
      .rxd        (rxd),
      .byteReq    (byteReq),
      .txSerial   (txSerial),
      .rxByte     (rxByte),
      .byteValid  (byteValid),
      .synced     (synced),
      .clocks     (clocks.sink),
      .txBusy     (txBusy),
      .rxData     (rxData),
      .rxValid    (rxValid),
      .rxSynced   (rxSynced),
      .txd        (txd),
      .txLineClk  (txLineClk),
      .rxLineClk  (rxLineClk),
      .nextByte   (nextByte),
      .sendEnable (sendEnable),
      .rxSerial   (rxSerial),
      .hunt       (hunt)
   );

   dupTransmitter transmitter0 (
      .clk        (clk),
      .rst        (rst),
      .clocks     (clocks.sink),
      .nextByte   (nextByte),
      .sendEnable (sendEnable),
      .byteReq    (byteReq),
      .txSerial   (txSerial)
   );

   dupReceiver receiver0 (
      .clk       (clk),
      .rst       (rst),
      .clocks    (clocks.sink),
      .rxSerial  (rxSerial),
      .hunt      (hunt),
      .rxByte    (rxByte),
      .byteValid (byteValid),
      .synced    (synced)
   );

endmodule

`default_nettype wire

// ==== verif/dupLinkTb.sv ====
// Directed testbench for the serial line unit top level.
// Runs reset, clock, internal loopback, diagnostic and modem tests in order.

`default_nettype none

module dupLinkTb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [10:0] CLK_DIV = 11'd4;
   localparam int BIT_CYCLES = 4 * (CLK_DIV + 1);
   // Five tests, about 40 byte times of 8 bits, with ample margin
   localparam int CYCLE_LIMIT = 60000;

   logic               clk;
   logic               rst;
   dupPkg::maintMode_t mode;
   logic               mco;
   logic               enable;
   dupPkg::dupByte_t   txData;
   logic               txLoad;
   logic               txClkIn;
   logic               rxClkIn;
   logic               rxd;
   logic               txBusy;
   dupPkg::dupByte_t   rxData;
   logic               rxValid;
   logic               rxSynced;
   logic               txd;
   logic               serialClk;
   logic               maintTimer;

   dupPkg::dupByte_t   rxQ[$];
   int                 cycles;
   int                 errorCount;
   int                 seed;

   dupLink #(
      .CLK_DIV (CLK_DIV)
   ) dut0 (
      .clk        (clk),
      .rst        (rst),
      .mode       (mode),
      .mco        (mco),
      .enable     (enable),
      .txData     (txData),
      .txLoad     (txLoad),
      .txClkIn    (txClkIn),
      .rxClkIn    (rxClkIn),
      .rxd        (rxd),
      .txBusy     (txBusy),
      .rxData     (rxData),
      .rxValid    (rxValid),
      .rxSynced   (rxSynced),
      .txd        (txd),
      .serialClk  (serialClk),
      .maintTimer (maintTimer)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   // Host side receive monitor
   always @(posedge clk)
   begin
      if (rxValid)
         rxQ.push_back(rxData);
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $fatal(1, "watchdog expired");
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   task automatic compareByte(input string name, input dupPkg::dupByte_t expected,
                              input dupPkg::dupByte_t actual);
      if (expected !== actual)
      begin
         errorCount = errorCount + 1;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "byte mismatch");
      end
   endtask

   task automatic compareBit(input string name, input logic expected, input logic actual);
      if (expected !== actual)
      begin
         errorCount = errorCount + 1;
         $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "level mismatch");
      end
   endtask

   task automatic compareCount(input string name, input int expected, input int actual);
      if (expected != actual)
      begin
         errorCount = errorCount + 1;
         $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "count mismatch");
      end
   endtask

   task automatic failPlain(input string what);
      errorCount = errorCount + 1;
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "check failed");
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic tick(input int n);
      repeat (n) @(posedge clk);
   endtask

   // Payload byte that is never the fill character
   function automatic dupPkg::dupByte_t randomByte();
      dupPkg::dupByte_t b;
      b = dupPkg::SYN_CHAR;
      while (b == dupPkg::SYN_CHAR)
         b = $random(seed);
      return b;
   endfunction

   // Disable and let the looped bit clock drain the transmitter
   task automatic quiesce();
      enable <= 1'b0;
      mode   <= dupPkg::MODE_INT;
      tick(20 * BIT_CYCLES);
   endtask

   task automatic loadByte(input dupPkg::dupByte_t b);
      int waitCount;
      waitCount = 0;
      while (txBusy)
      begin
         tick(1);
         waitCount = waitCount + 1;
         if (waitCount > 40 * BIT_CYCLES)
            failPlain("Transmit buffer never became free");
      end
      txData <= b;
      txLoad <= 1'b1;
      tick(1);
      txLoad <= 1'b0;
      tick(1);
   endtask

   // One half period of the hand-driven bit clock
   task automatic mcoHalf(input logic level);
      mco <= level;
      repeat (6)
      begin
         @(posedge clk);
         compareBit("diagBitBang serialClk", level, serialClk);
      end
   endtask

   // Modem bit samples txd on the rise and changes rxd while high
   task automatic modemBit(input logic rxBit, output logic txBit);
      @(posedge clk);
      txBit = txd;
      txClkIn <= 1'b1;
      rxClkIn <= 1'b1;
      tick(2);
      rxd <= rxBit;
      tick(4);
      txClkIn <= 1'b0;
      rxClkIn <= 1'b0;
      tick(5);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic resetState();
      int i;
      for (i = 0; i < 13; i++)
      begin
         @(posedge clk);
         if (i == 9)
            rst <= 1'b0;
         compareBit("resetState txBusy", 1'b0, txBusy);
         compareBit("resetState rxValid", 1'b0, rxValid);
         compareBit("resetState rxSynced", 1'b0, rxSynced);
         compareBit("resetState serialClk", 1'b0, serialClk);
         compareBit("resetState maintTimer", 1'b0, maintTimer);
         compareBit("resetState txd", 1'b1, txd);
      end
   endtask

   task automatic clockTimer();
      int   i;
      int   firstRise;
      int   secondRise;
      logic prev;
      logic level;
      quiesce();
      firstRise  = -1;
      secondRise = -1;
      prev       = serialClk;
      for (i = 0; i < 5 * BIT_CYCLES && secondRise < 0; i++)
      begin
         tick(1);
         if (serialClk && !prev)
         begin
            if (firstRise < 0)
               firstRise = i;
            else
               secondRise = i;
         end
         // High for the first half of each period after the first rise
         if (firstRise >= 0)
         begin
            level = ((i - firstRise) % BIT_CYCLES) < (BIT_CYCLES / 2);
            compareBit("clockTimer maintTimer", level, maintTimer);
         end
         prev = serialClk;
      end
      if (secondRise < 0)
         failPlain("Bit clock did not toggle in internal loopback");
      compareCount("clockTimer period", BIT_CYCLES, secondRise - firstRise);
      mode <= dupPkg::MODE_USER;
      tick(2);
      repeat (3 * BIT_CYCLES)
      begin
         tick(1);
         compareBit("clockTimer user maintTimer", 1'b0, maintTimer);
      end
   endtask

   task automatic internalLoop();
      dupPkg::dupByte_t sent[$];
      int               i;
      quiesce();
      rxQ.delete();
      enable <= 1'b1;
      tick(2);
      for (i = 0; i < 6; i++)
      begin
         sent.push_back(randomByte());
         loadByte(sent[i]);
      end
      i = 0;
      while (rxQ.size() < 6 && i < 20 * 8 * BIT_CYCLES)
      begin
         tick(1);
         i = i + 1;
      end
      compareBit("internalLoop rxSynced", 1'b1, rxSynced);
      // Idle time with only fill on the line
      tick(4 * 8 * BIT_CYCLES);
      compareCount("internalLoop byte count", 6, rxQ.size());
      for (i = 0; i < 6; i++)
         compareByte("internalLoop rxData", sent[i], rxQ[i]);
   endtask

   task automatic diagBitBang();
      dupPkg::dupByte_t b;
      int               n;
      quiesce();
      mco  <= 1'b0;
      mode <= dupPkg::MODE_DIAG;
      tick(4);
      rxQ.delete();
      enable <= 1'b1;
      tick(2);
      b = randomByte();
      loadByte(b);
      for (n = 0; n < 60 && rxQ.size() == 0; n++)
      begin
         mcoHalf(1'b1);
         mcoHalf(1'b0);
      end
      if (rxQ.size() == 0)
         failPlain("No byte came through the diagnostic loop");
      compareByte("diagBitBang rxData", b, rxQ[0]);
   endtask

   task automatic userModem();
      logic             txBits[48];
      logic             rxBits[48];
      dupPkg::dupByte_t a;
      dupPkg::dupByte_t b;
      dupPkg::dupByte_t sent;
      dupPkg::dupByte_t got;
      int               first;
      int               i;
      int               j;
      int               k;
      quiesce();
      txClkIn <= 1'b0;
      rxClkIn <= 1'b0;
      rxd     <= 1'b1;
      mode    <= dupPkg::MODE_USER;
      tick(4);
      rxQ.delete();
      a    = randomByte();
      b    = randomByte();
      sent = randomByte();
      // Mark, sync, two bytes, then fill
      for (j = 0; j < 8; j++)
      begin
         rxBits[j]      = 1'b1;
         rxBits[8 + j]  = dupPkg::SYN_CHAR[j];
         rxBits[16 + j] = a[j];
         rxBits[24 + j] = b[j];
         rxBits[32 + j] = dupPkg::SYN_CHAR[j];
         rxBits[40 + j] = dupPkg::SYN_CHAR[j];
      end
      enable <= 1'b1;
      tick(2);
      loadByte(sent);
      for (i = 0; i < 48; i++)
         modemBit(rxBits[i], txBits[i]);
      // Sync starts with a zero bit
      first = -1;
      for (i = 0; i < 48; i++)
         if (first < 0 && !txBits[i])
            first = i;
      if (first < 0 || first > 24)
         failPlain("No preamble seen on txd");
      for (k = 0; k < 3; k++)
      begin
         for (j = 0; j < 8; j++)
            got[j] = txBits[first + 8 * k + j];
         compareByte("userModem txd", (k < 2) ? dupPkg::SYN_CHAR : sent, got);
      end
      compareBit("userModem rxSynced", 1'b1, rxSynced);
      if (rxQ.size() < 2)
         failPlain("Modem bytes did not arrive on rxData");
      compareByte("userModem first byte", a, rxQ[0]);
      compareByte("userModem second byte", b, rxQ[1]);
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      rst        = 1'b1;
      mode       = dupPkg::MODE_USER;
      mco        = 1'b0;
      enable     = 1'b0;
      txData     = '0;
      txLoad     = 1'b0;
      txClkIn    = 1'b0;
      rxClkIn    = 1'b0;
      rxd        = 1'b1;
      cycles     = 0;
      errorCount = 0;
      seed       = 32'h80e568e9;
      resetState();
      clockTimer();
      internalLoop();
      diagBitBang();
      userModem();
      if (errorCount == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dupLink.f ====
logic/dupPkg.sv
logic/dupClockIf.sv
logic/dupClock.sv
logic/dupTransmitter.sv
logic/dupReceiver.sv
logic/dupControl.sv
logic/dupLink.sv
verif/dupLinkTb.sv

// ==== Bender.yml ====
package:
  name: dupLink

sources:
  - logic/dupPkg.sv
  - logic/dupClockIf.sv
  - logic/dupClock.sv
  - logic/dupTransmitter.sv
  - logic/dupReceiver.sv
  - logic/dupControl.sv
  - logic/dupLink.sv
  - target: simulation
    files:
      - verif/dupLinkTb.sv
